// ==== hw/lsu_defines.svh ====
`ifndef LSU_DEFINES_SVH
`define LSU_DEFINES_SVH

// data RAM depth as log2 of the number of 32-bit words
// 8 gives 256 words, 1 KiB
`define LSU_RAM_WORDS_LOG2 8

// cycles from a read beat to valid read data, 1 or more
`define LSU_RAM_READ_LATENCY 2

`endif

// ==== hw/lsu_pkg.sv ====
`default_nettype none

package lsu_pkg;

	// access size of a load or store
	typedef enum logic [1:0]
	{
		len_byte = 2'd0,
		len_half = 2'd1,
		len_word = 2'd2
	} access_len_e;

	// byte address split into word index and byte lane
	typedef struct packed
	{
		logic [29:0] index;
		logic [1:0]  offset;
	} lsu_addr_s;

	// one address word, decoded either whole or as index/offset
	typedef union packed
	{
		logic [31:0] raw;
		lsu_addr_s   fields;
	} lsu_addr_u;

endpackage

`default_nettype wire

// ==== hw/mem_port_if.sv ====
`timescale 1ns/1ps
`default_nettype none

// one RAM beat, shared by sequencer, aligner, merger and RAM
interface mem_port_if;

	logic        beat_valid;
	logic        beat_we;
	logic        second_beat;  // upper half of a split access
	logic [29:0] word_addr;
	logic [3:0]  wmask;
	logic [31:0] wdata;
	logic        rvalid;
	logic [31:0] rdata;

	modport sequencer (output beat_valid, output beat_we, output second_beat, input rvalid);

	modport aligner (input second_beat, output word_addr, output wmask, output wdata);

	modport merger (input rdata);

	modport ram (input beat_valid, input beat_we, input word_addr, input wmask, input wdata,
		output rvalid, output rdata);

endinterface

`default_nettype wire

// ==== hw/access_sequencer.sv ====
`timescale 1ns/1ps
`default_nettype none

module access_sequencer
(
	input  logic                     clk_i,
	input  logic                     reset_i,
	input  logic                     req_i,
	input  logic                     store_i,
	input  lsu_pkg::access_len_e     len_i,
	input  lsu_pkg::lsu_addr_u       addr_i,
	input  logic                     timer_done_i,
	mem_port_if.sequencer            mem,
	output logic                     timer_start_o,
	output logic                     capture_first_o,
	output logic                     capture_second_o,
	output logic                     finish_o,
	output logic                     busy_o,
	output logic                     done_o,
	output logic                     split_o
);

	localparam logic [2:0] st_idle   = 3'd0;
	localparam logic [2:0] st_first  = 3'd1;
	localparam logic [2:0] st_wait1  = 3'd2;
	localparam logic [2:0] st_second = 3'd3;
	localparam logic [2:0] st_wait2  = 3'd4;
	localparam logic [2:0] st_done   = 3'd5;

	logic [2:0] state;
	logic       store_q;
	logic       split_q;
	logic       misaligned;
	logic       accept;
	logic       beat_back;

	// word at nonzero offset, or halfword crossing into the next word
	always_comb
	begin
		case (len_i)
			lsu_pkg::len_word: misaligned = (addr_i.fields.offset != 2'd0);
			lsu_pkg::len_half: misaligned = (addr_i.fields.offset == 2'd3);
			default:           misaligned = 1'b0;
		endcase
	end

	assign busy_o    = (state != st_idle) && (state != st_done);
	assign accept    = req_i && !busy_o; // also taken in the done cycle
	assign beat_back = timer_done_i && mem.rvalid;

	always_ff @(posedge clk_i)
	begin
		if (!reset_i)
		begin
			state   <= st_idle;
			store_q <= 1'b0;
			split_q <= 1'b0;
		end
		else
		begin
			case (state)
				st_idle, st_done:
				begin
					if (accept)
					begin
						state   <= st_first;
						store_q <= store_i;
						split_q <= misaligned;
					end
					else
						state <= st_idle;
				end
				st_first:  state <= !store_q ? st_wait1 : (split_q ? st_second : st_done);
				st_wait1:  if (beat_back) state <= split_q ? st_second : st_done;
				st_second: state <= store_q ? st_done : st_wait2;
				st_wait2:  if (beat_back) state <= st_done;
				default:   state <= st_idle;
			endcase
		end
	end

	assign mem.beat_valid  = (state == st_first) || (state == st_second);
	assign mem.beat_we     = mem.beat_valid && store_q;
	assign mem.second_beat = (state == st_second) || (state == st_wait2);

	assign timer_start_o    = mem.beat_valid && !store_q; // only loads wait
	assign capture_first_o  = (state == st_wait1) && beat_back;
	assign capture_second_o = (state == st_wait2) && beat_back;

	assign done_o   = (state == st_done);
	assign finish_o = done_o;
	assign split_o  = done_o && split_q;

endmodule

`default_nettype wire

// ==== hw/mem_wait_timer.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "lsu_defines.svh"

module mem_wait_timer
(
	input  logic clk_i,
	input  logic reset_i,
	input  logic start_i,
	output logic done_o
);

	localparam int lat   = `LSU_RAM_READ_LATENCY;
	localparam int cnt_w = $clog2(lat + 1);

	logic [cnt_w-1:0] count;
	logic             running;

	// loaded one short so done lands lat cycles after start
	always_ff @(posedge clk_i)
	begin
		if (!reset_i)
		begin
			running <= 1'b0;
			count   <= '0;
		end
		else if (start_i)
		begin
			running <= 1'b1; // restart even if still counting
			count   <= cnt_w'(lat - 1);
		end
		else if (running)
		begin
			if (count == '0)
				running <= 1'b0;
			else
				count <= count - 1'b1;
		end
	end

	assign done_o = running && (count == '0);

endmodule

`default_nettype wire

// ==== hw/store_aligner.sv ====
`timescale 1ns/1ps
`default_nettype none

module store_aligner
(
	input  logic                 clk_i,
	input  logic                 reset_i,
	input  logic                 req_i,
	input  lsu_pkg::access_len_e len_i,
	input  lsu_pkg::lsu_addr_u   addr_i,
	input  logic [31:0]          wdata_i,
	mem_port_if.aligner          mem
);

	lsu_pkg::lsu_addr_u   addr_q;
	lsu_pkg::access_len_e len_q;
	logic [31:0]          data_q;
	logic [3:0]           base_mask;
	logic [2:0]           back_bytes;

	// request fields held for both beats
	always_ff @(posedge clk_i)
	begin
		if (!reset_i)
		begin
			addr_q <= '0;
			len_q  <= lsu_pkg::len_byte;
		end
		else if (req_i)
		begin
			addr_q <= addr_i;
			len_q  <= len_i;
		end
	end

	always_ff @(posedge clk_i)
	begin
		if (req_i)
			data_q <= wdata_i;
	end

	always_comb
	begin
		case (len_q)
			lsu_pkg::len_byte: base_mask = 4'b0001;
			lsu_pkg::len_half: base_mask = 4'b0011;
			default:           base_mask = 4'b1111;
		endcase
	end

	// bytes already written by the first beat
	assign back_bytes = 3'd4 - {1'b0, addr_q.fields.offset};

	always_comb
	begin
		if (!mem.second_beat)
		begin
			mem.word_addr = addr_q.fields.index;
			mem.wmask     = base_mask << addr_q.fields.offset;
			mem.wdata     = data_q << {addr_q.fields.offset, 3'b000};
		end
		else
		begin
			mem.word_addr = addr_q.fields.index + 30'd1; // spill into next word
			mem.wmask     = base_mask >> back_bytes;
			mem.wdata     = data_q >> {back_bytes, 3'b000};
		end
	end

endmodule

`default_nettype wire

// ==== hw/load_merger.sv ====
`timescale 1ns/1ps
`default_nettype none

module load_merger
(
	input  logic                 clk_i,
	input  logic                 reset_i,
	input  logic                 req_i,
	input  lsu_pkg::access_len_e len_i,
	input  logic                 unsigned_i,
	input  logic [1:0]           offset_i,
	input  logic                 capture_first_i,
	input  logic                 capture_second_i,
	input  logic                 finish_i,
	mem_port_if.merger           mem,
	output logic [31:0]          rdata_o
);

	lsu_pkg::access_len_e len_q;
	logic                 unsigned_q;
	logic [1:0]           offset_q;
	logic [23:0]          first_q;
	logic [31:0]          result_q;
	logic [31:0]          shifted;
	logic [31:0]          merged;
	logic [2:0]           back_bytes;

	function automatic logic [31:0] extend(input logic [31:0] value,
		input lsu_pkg::access_len_e len, input logic is_unsigned);
		case (len)
			lsu_pkg::len_byte: return {{24{~is_unsigned & value[7]}}, value[7:0]};
			lsu_pkg::len_half: return {{16{~is_unsigned & value[15]}}, value[15:0]};
			default:           return value;
		endcase
	endfunction

	always_ff @(posedge clk_i)
	begin
		if (!reset_i)
		begin
			len_q      <= lsu_pkg::len_byte;
			unsigned_q <= 1'b0;
			offset_q   <= 2'd0;
		end
		else if (req_i)
		begin
			len_q      <= len_i;
			unsigned_q <= unsigned_i;
			offset_q   <= offset_i;
		end
	end

	// requested bytes moved down to lane 0
	assign shifted = mem.rdata >> {offset_q, 3'b000};

	// low bytes of the second word sit above the held first-word bytes
	assign back_bytes = 3'd4 - {1'b0, offset_q};
	assign merged     = (mem.rdata << {back_bytes, 3'b000}) | {8'h00, first_q};

	always_ff @(posedge clk_i)
	begin
		if (capture_first_i)
			first_q <= shifted[23:0]; // upper bytes of the first word
		if (capture_first_i || capture_second_i)
			result_q <= extend(capture_second_i ? merged : shifted, len_q, unsigned_q);
	end

	assign rdata_o = finish_i ? result_q : 32'd0;

endmodule

`default_nettype wire

// ==== hw/data_ram.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "lsu_defines.svh"

module data_ram
(
	input  logic     clk_i,
	mem_port_if.ram  mem
);

	localparam int aw    = `LSU_RAM_WORDS_LOG2;
	localparam int depth = 1 << aw;
	localparam int lat   = `LSU_RAM_READ_LATENCY;

	logic [31:0]   ram [depth];
	logic [aw-1:0] idx;
	logic [31:0]   rd_data [lat];
	logic [lat-1:0] rd_valid;

	assign idx = mem.word_addr[aw-1:0]; // wraps modulo depth

	// byte-masked write at the beat edge
	always_ff @(posedge clk_i)
	begin
		if (mem.beat_valid && mem.beat_we)
		begin
			for (int b = 0; b < 4; b++)
			begin
				if (mem.wmask[b])
					ram[idx][8*b +: 8] <= mem.wdata[8*b +: 8];
			end
		end
	end

	// read pipeline, valid travels with the data
	always_ff @(posedge clk_i)
	begin
		rd_valid[0] <= mem.beat_valid && !mem.beat_we;
		rd_data[0]  <= ram[idx];
		for (int i = 1; i < lat; i++)
		begin
			rd_valid[i] <= rd_valid[i-1];
			rd_data[i]  <= rd_data[i-1];
		end
	end

	assign mem.rvalid = rd_valid[lat-1];
	assign mem.rdata  = rd_data[lat-1];

endmodule

`default_nettype wire

// ==== hw/lsu_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module lsu_top
(
	input  logic                 clk_i,
	input  logic                 reset_i,
	input  logic                 req_i,
	input  logic                 store_i,
	input  logic                 unsigned_i,
	input  lsu_pkg::access_len_e len_i,
	input  logic [31:0]          addr_i,
	input  logic [31:0]          wdata_i,
	output logic                 busy_o,
	output logic                 done_o,
	output logic                 split_o,
	output logic [31:0]          rdata_o
);

	lsu_pkg::lsu_addr_u req_addr;
	logic               accept;
	logic               timer_start;
	logic               timer_done;
	logic               capture_first;
	logic               capture_second;
	logic               finish;

	mem_port_if mem ();

	assign req_addr.raw = addr_i;
	assign accept       = req_i && !busy_o; // request fields sampled only here

	access_sequencer u_sequencer
	(
		.clk_i            (clk_i),
		.reset_i          (reset_i),
		.req_i            (req_i),
		.store_i          (store_i),
		.len_i            (len_i),
		.addr_i           (req_addr),
		.timer_done_i     (timer_done),
		.mem              (mem),
		.timer_start_o    (timer_start),
		.capture_first_o  (capture_first),
		.capture_second_o (capture_second),
		.finish_o         (finish),
		.busy_o           (busy_o),
		.done_o           (done_o),
		.split_o          (split_o)
	);

	mem_wait_timer u_timer
	(
		.clk_i   (clk_i),
		.reset_i (reset_i),
		.start_i (timer_start),
		.done_o  (timer_done)
	);

	store_aligner u_aligner
	(
		.clk_i   (clk_i),
		.reset_i (reset_i),
		.req_i   (accept),
		.len_i   (len_i),
		.addr_i  (req_addr),
		.wdata_i (wdata_i),
		.mem     (mem)
	);

	load_merger u_merger
	(
		.clk_i            (clk_i),
		.reset_i          (reset_i),
		.req_i            (accept),
		.len_i            (len_i),
		.unsigned_i       (unsigned_i),
		.offset_i         (req_addr.fields.offset),
		.capture_first_i  (capture_first),
		.capture_second_i (capture_second),
		.finish_i         (finish),
		.mem              (mem),
		.rdata_o          (rdata_o)
	);

	data_ram u_ram
	(
		.clk_i (clk_i),
		.mem   (mem)
	);

endmodule

`default_nettype wire

// ==== bench/clock_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module clock_gen
(
	output logic clk_o,
	output logic reset_o
);

	initial
	begin
		clk_o = 1'b0;
		forever #20 clk_o = ~clk_o; // 40 ns period
	end

	// active low, released just after the 8th rising edge
	initial
	begin
		reset_o = 1'b0;
		repeat (8) @(posedge clk_o);
		#1 reset_o = 1'b1;
	end

endmodule

`default_nettype wire

// ==== bench/lsu_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "lsu_defines.svh"

module lsu_tb;

	localparam int ram_aw = `LSU_RAM_WORDS_LOG2 + 2; // byte address bits of the RAM
	localparam int timeout_cycles = 100;
	localparam lsu_pkg::access_len_e lb = lsu_pkg::len_byte;
	localparam lsu_pkg::access_len_e lh = lsu_pkg::len_half;
	localparam lsu_pkg::access_len_e lw = lsu_pkg::len_word;

	typedef struct
	{
		logic                 store;
		lsu_pkg::access_len_e len;
		logic                 uns;
		logic [31:0]          addr;
		logic [31:0]          wdata;
		logic                 split;
	} op_t;

	logic                 clk_i;
	logic                 reset_i;
	logic                 req_i;
	logic                 store_i;
	logic                 unsigned_i;
	lsu_pkg::access_len_e len_i;
	logic [31:0]          addr_i;
	logic [31:0]          wdata_i;
	logic                 busy_o;
	logic                 done_o;
	logic                 split_o;
	logic [31:0]          rdata_o;

	int         checks;
	int         errors;
	int         timeouts;
	logic [7:0] model [1 << ram_aw]; // little-endian byte image of the RAM
	op_t        ops [$];

	clock_gen u_clock
	(
		.clk_o   (clk_i),
		.reset_o (reset_i)
	);

	lsu_top UUT (.*);

	task automatic check_value(input string what, input logic [31:0] got,
		input logic [31:0] exp);
		checks++;
		if (got !== exp)
		begin
			errors++;
			$display("[ERROR] %0t ns: %s: got %h, expected %h", $time, what, got, exp);
		end
	endtask

	function automatic int byte_count(input lsu_pkg::access_len_e len);
		return (len == lsu_pkg::len_byte) ? 1 : (len == lsu_pkg::len_half) ? 2 : 4;
	endfunction

	// access runs past the last byte of its word
	function automatic logic expected_split(input lsu_pkg::access_len_e len,
		input logic [31:0] addr);
		return (int'(addr[1:0]) + byte_count(len)) > 4;
	endfunction

	function automatic logic [31:0] expected_load(input logic [31:0] addr,
		input lsu_pkg::access_len_e len, input logic uns);
		logic [31:0] value;
		logic [31:0] byte_addr;
		int          nbytes;
		nbytes = byte_count(len);
		value  = 32'd0;
		for (int i = 0; i < nbytes; i++)
		begin
			byte_addr = addr + 32'(i);
			value[8*i +: 8] = model[byte_addr[ram_aw-1:0]];
		end
		if (!uns && value[8*nbytes-1])
		begin
			for (int i = nbytes; i < 4; i++)
				value[8*i +: 8] = 8'hff; // sign fill
		end
		return value;
	endfunction

	function automatic logic [31:0] fill_value(input logic [31:0] addr);
		return (addr * 32'h9e37_79b1) ^ {addr[15:0], ~addr[15:0]};
	endfunction

	task automatic add_op(input logic store, input lsu_pkg::access_len_e len, input logic uns,
		input logic [31:0] addr, input logic [31:0] wdata, input logic split);
		ops.push_back('{store, len, uns, addr, wdata, split});
	endtask

	task automatic run_op(input logic store, input lsu_pkg::access_len_e len, input logic uns,
		input logic [31:0] addr, input logic [31:0] wdata, input logic exp_split);
		string       what;
		logic [31:0] exp_data;
		logic [31:0] byte_addr;
		int          waited;
		if (timeouts != 0)
			return;
		what     = $sformatf("%s %s at %h", store ? "store" : "load", len.name(), addr);
		exp_data = expected_load(addr, len, uns);
		@(posedge clk_i);
		#1;
		req_i      = 1'b1;
		store_i    = store;
		len_i      = len;
		unsigned_i = uns;
		addr_i     = addr;
		wdata_i    = wdata;
		@(posedge clk_i);
		#1;
		req_i  = 1'b0;
		waited = 0;
		while (!done_o && waited < timeout_cycles)
		begin
			@(posedge clk_i);
			#1;
			waited++;
		end
		if (!done_o)
		begin
			$display("timeout: %s never signalled done", what);
			timeouts++;
			return;
		end
		check_value({what, " split"}, 32'(split_o), 32'(exp_split));
		check_value({what, " busy at done"}, 32'(busy_o), 32'd0);
		if (!store)
			check_value({what, " data"}, rdata_o, exp_data);
		else
		begin
			for (int i = 0; i < byte_count(len); i++)
			begin
				byte_addr = addr + 32'(i);
				model[byte_addr[ram_aw-1:0]] = wdata[8*i +: 8];
			end
		end
	endtask

	task automatic random_op;
		logic                 store;
		lsu_pkg::access_len_e len;
		logic                 uns;
		logic [31:0]          addr;
		store = 1'($urandom_range(1, 0));
		len   = lsu_pkg::access_len_e'(2'($urandom_range(2, 0)));
		uns   = 1'($urandom_range(1, 0));
		addr  = $urandom(); // high bits exercise index wrap
		run_op(store, len, uns, addr, $urandom(), expected_split(len, addr));
	endtask

	// outputs sampled mid-cycle, away from the reset release
	task automatic check_reset;
		int waited;
		waited = 0;
		@(negedge clk_i);
		while (!reset_i && waited < 20)
		begin
			check_value("busy_o in reset", 32'(busy_o), 32'd0);
			check_value("done_o in reset", 32'(done_o), 32'd0);
			@(negedge clk_i);
			waited++;
		end
		if (!reset_i)
		begin
			$display("timeout: reset was never released");
			timeouts++;
		end
		repeat (2)
		begin
			check_value("busy_o before first request", 32'(busy_o), 32'd0);
			check_value("done_o before first request", 32'(done_o), 32'd0);
			@(negedge clk_i);
		end
	endtask

	// load accepted, then a store pulsed while the load is still busy
	task automatic check_ignored_request(input logic [31:0] addr);
		logic [31:0] exp_data;
		logic [31:0] got;
		int          dones;
		if (timeouts != 0)
			return;
		exp_data = expected_load(addr, lw, 1'b0);
		@(posedge clk_i);
		#1;
		req_i      = 1'b1;
		store_i    = 1'b0;
		len_i      = lw;
		unsigned_i = 1'b0;
		addr_i     = addr;
		wdata_i    = 32'd0;
		@(posedge clk_i);
		#1;
		req_i = 1'b0;
		@(posedge clk_i);
		#1;
		check_value("busy_o while load in flight", 32'(busy_o), 32'd1);
		req_i   = 1'b1;
		store_i = 1'b1;
		wdata_i = ~exp_data;
		@(posedge clk_i);
		#1;
		req_i   = 1'b0;
		store_i = 1'b0;
		dones   = 0;
		got     = 32'd0;
		for (int i = 0; i < 20; i++)
		begin
			if (done_o)
			begin
				dones++;
				got = rdata_o;
			end
			@(posedge clk_i);
			#1;
		end
		check_value("done pulses for one accepted request", 32'(dones), 32'd1);
		check_value("load data beside ignored store", got, exp_data);
	endtask

	task automatic build_table;
		add_op(1'b1, lw, 1'b0, 32'h0000_0100, 32'h1122_3344, 1'b0);
		add_op(1'b0, lw, 1'b0, 32'h0000_0100, 32'h0, 1'b0);
		add_op(1'b1, lb, 1'b0, 32'h0000_0105, 32'h0000_00a5, 1'b0);
		add_op(1'b0, lb, 1'b1, 32'h0000_0105, 32'h0, 1'b0);
		add_op(1'b0, lb, 1'b0, 32'h0000_0105, 32'h0, 1'b0); // negative byte
		add_op(1'b1, lh, 1'b0, 32'h0000_010a, 32'h0000_beef, 1'b0);
		add_op(1'b0, lh, 1'b0, 32'h0000_010a, 32'h0, 1'b0);
		add_op(1'b0, lh, 1'b1, 32'h0000_010a, 32'h0, 1'b0);
		add_op(1'b0, lw, 1'b0, 32'h0000_0108, 32'h0, 1'b0);
		add_op(1'b1, lw, 1'b0, 32'h0000_01fd, 32'hcafe_f00d, 1'b1);
		add_op(1'b0, lw, 1'b0, 32'h0000_01fd, 32'h0, 1'b1);
		add_op(1'b0, lw, 1'b0, 32'h0000_01fc, 32'h0, 1'b0);
		add_op(1'b0, lw, 1'b0, 32'h0000_0200, 32'h0, 1'b0);
		add_op(1'b1, lw, 1'b0, 32'h0000_0202, 32'h89ab_cdef, 1'b1);
		add_op(1'b0, lw, 1'b0, 32'h0000_0202, 32'h0, 1'b1);
		add_op(1'b0, lw, 1'b0, 32'h0000_0200, 32'h0, 1'b0);
		add_op(1'b0, lw, 1'b0, 32'h0000_0204, 32'h0, 1'b0);
		add_op(1'b1, lw, 1'b0, 32'h0000_020b, 32'h0123_4567, 1'b1);
		add_op(1'b0, lw, 1'b0, 32'h0000_020b, 32'h0, 1'b1);
		add_op(1'b0, lw, 1'b0, 32'h0000_0208, 32'h0, 1'b0);
		add_op(1'b0, lw, 1'b0, 32'h0000_020c, 32'h0, 1'b0);
		add_op(1'b1, lh, 1'b0, 32'h0000_0213, 32'h0000_8001, 1'b1);
		add_op(1'b0, lh, 1'b0, 32'h0000_0213, 32'h0, 1'b1);
		add_op(1'b0, lh, 1'b1, 32'h0000_0213, 32'h0, 1'b1);
		add_op(1'b0, lw, 1'b0, 32'h0000_0210, 32'h0, 1'b0);
		add_op(1'b0, lw, 1'b0, 32'h0000_0214, 32'h0, 1'b0);
		add_op(1'b1, lw, 1'b0, 32'h0000_03fe, 32'hdead_beef, 1'b1); // wraps to word 0
		add_op(1'b0, lw, 1'b0, 32'h0000_03fe, 32'h0, 1'b1);
		add_op(1'b0, lw, 1'b0, 32'h0000_0000, 32'h0, 1'b0);
		add_op(1'b0, lh, 1'b0, 32'h0000_03ff, 32'h0, 1'b1);
		add_op(1'b0, lb, 1'b0, 32'h0000_03ff, 32'h0, 1'b0);
	endtask

	initial
	begin
		req_i      = 1'b0;
		store_i    = 1'b0;
		unsigned_i = 1'b0;
		len_i      = lsu_pkg::len_byte;
		addr_i     = 32'd0;
		wdata_i    = 32'd0;
		checks     = 0;
		errors     = 0;
		timeouts   = 0;
		void'($urandom(32'h34b2_efa8));
		build_table();
		check_reset();
		// known contents everywhere before any load
		for (int w = 0; w < (1 << `LSU_RAM_WORDS_LOG2); w++)
			run_op(1'b1, lw, 1'b0, 32'(w) << 2, fill_value(32'(w) << 2), 1'b0);
		foreach (ops[i])
			run_op(ops[i].store, ops[i].len, ops[i].uns, ops[i].addr, ops[i].wdata,
				ops[i].split);
		check_ignored_request(32'h0000_0300);
		run_op(1'b0, lw, 1'b0, 32'h0000_0300, 32'h0, 1'b0); // word still untouched
		for (int n = 0; n < 200; n++)
			random_op();
		$display("checks %0d, errors %0d, timeouts %0d", checks, errors, timeouts);
		if (errors == 0 && timeouts == 0)
			$display("All tests passed");
		else
			$display("Some tests failed");
		$finish;
	end

endmodule

`default_nettype wire

// ==== compile.f ====
+incdir+hw
hw/lsu_pkg.sv
hw/mem_port_if.sv
hw/access_sequencer.sv
hw/mem_wait_timer.sv
hw/store_aligner.sv
hw/load_merger.sv
hw/data_ram.sv
hw/lsu_top.sv
bench/clock_gen.sv
bench/lsu_tb.sv

// ==== Makefile ====
TOP = lsu_tb

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing -Wno-fatal -f compile.f --top-module $(TOP) -o $(TOP)_sim

run: build
	@out="$$(./obj_dir/$(TOP)_sim)"; echo "$$out"; echo "$$out" | grep -q "All tests passed"

lint:
	verilator --lint-only --timing -Wall -f compile.f --top-module $(TOP)

clean:
	rm -rf obj_dir
